/* chan_pkg.sv */
`default_nettype none

package chan_pkg;

    typedef logic [7:0] byte_t;

    // Entries per channel buffer
    localparam int BUF_DEPTH = 16;

    typedef logic [4:0] cnt_t;      // Fill count, 0 to 16
    typedef logic [7:0] trig_t;     // Idle timeout in ticks

    // 10 us at 50 MHz
    localparam int TICK_DIV_DEFAULT = 500;

endpackage

`default_nettype wire

/* channel_select.sv */
`timescale 1ns/100ps
`default_nettype none

module channel_select import chan_pkg::*; #(
    parameter int NUM_CHAN = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_CHAN-1:0]   ready,
    input  byte_t [NUM_CHAN-1:0]  heads,
    input  cnt_t [NUM_CHAN-1:0]   counts,
    input  logic                  grant,
    input  logic                  pop,
    output logic                  any_ready,
    output byte_t                 sel_chan,
    output cnt_t                  sel_count,
    output byte_t                 sel_data,
    output logic [NUM_CHAN-1:0]   pop_vec,
    output logic [NUM_CHAN-1:0]   granted_vec
);

    localparam int CHW = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

    logic [CHW-1:0] pri_idx;
    logic [CHW-1:0] chan_q;

    // Lowest ready channel wins
    always_comb begin
        pri_idx = '0;
        for (int i = NUM_CHAN - 1; i >= 0; i--) begin
            if (ready[i]) begin
                pri_idx = CHW'(i);
            end
        end
    end

    assign any_ready = |ready;
    assign sel_count = counts[pri_idx];    // Sampled as length at grant
    assign sel_chan  = byte_t'(chan_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chan_q <= '0;
        end else if (grant) begin
            chan_q <= pri_idx;
        end
    end

    always_ff @(posedge clk) begin
        sel_data <= heads[chan_q];
    end

    always_comb begin
        pop_vec             = '0;
        granted_vec         = '0;
        pop_vec[chan_q]     = pop;
        granted_vec[pri_idx] = grant;   // The channel being latched
    end

endmodule

`default_nettype wire

/* crc16_calc.sv */
`timescale 1ns/100ps
`default_nettype none

module crc16_calc import chan_pkg::*; import frame_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  en,
    input  byte_t data_in,
    output crc_t  crc
);

    crc_t crc_next;

    // One byte folded in per cycle, LSB first
    always_comb begin
        crc_next = crc ^ {8'h00, data_in};
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= CRC_INIT;
        end else if (clear) begin
            crc <= CRC_INIT;
        end else if (en) begin
            crc <= crc_next;
        end
    end

endmodule

`default_nettype wire

/* frame_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_fsm import chan_pkg::*; import frame_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  any_ready,
    input  byte_t sel_chan,
    input  cnt_t  sel_count,
    input  byte_t sel_data,
    input  crc_t  crc_value,
    input  logic  tx_busy,
    output logic  grant,
    output logic  pop,
    output logic  crc_clear,
    output logic  crc_en,
    output byte_t crc_byte,
    output byte_t tx_data,
    output logic  tx_strobe
);

    frame_state_e state;
    frame_state_e state_nxt;
    logic [2:0]   pace;
    cnt_t         len;
    cnt_t         sent;
    logic         fire;
    logic         done;

    assign fire = (state != ST_IDLE) && (pace == PACE_STROBE) && !tx_busy;
    assign done = (state != ST_IDLE) && (pace == PACE_DONE);

    assign grant     = (state == ST_IDLE) && any_ready;
    assign crc_clear = grant;               // Fresh CRC per frame
    assign tx_strobe = fire;
    assign pop       = fire && (state == ST_DATA);
    assign crc_en    = pop;
    assign crc_byte  = sel_data;

    always_comb begin
        case (state)
            ST_HDR0:   tx_data = HDR0;
            ST_HDR1:   tx_data = HDR1;
            ST_HDR2:   tx_data = HDR2;
            ST_HDR3:   tx_data = HDR3;
            ST_LEN:    tx_data = byte_t'(len);
            ST_CHAN:   tx_data = sel_chan + 8'd1;   // Numbered from 1 on the wire
            ST_DATA:   tx_data = sel_data;
            ST_CRC_LO: tx_data = crc_value[7:0];
            ST_CRC_HI: tx_data = crc_value[15:8];
            ST_END:    tx_data = END_BYTE;
            default:   tx_data = 8'h00;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (any_ready) begin
                    state_nxt = ST_HDR0;
                end
            end
            ST_HDR0:   if (done) state_nxt = ST_HDR1;
            ST_HDR1:   if (done) state_nxt = ST_HDR2;
            ST_HDR2:   if (done) state_nxt = ST_HDR3;
            ST_HDR3:   if (done) state_nxt = ST_LEN;
            ST_LEN:    if (done) state_nxt = ST_CHAN;
            ST_CHAN:   if (done) state_nxt = ST_DATA;
            ST_DATA: begin
                if (done && (sent + 1'b1 == len)) begin
                    state_nxt = ST_CRC_LO;  // Last payload byte out
                end
            end
            ST_CRC_LO: if (done) state_nxt = ST_CRC_HI;
            ST_CRC_HI: if (done) state_nxt = ST_END;
            ST_END:    if (done) state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            pace  <= '0;
            len   <= '0;
            sent  <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_IDLE) begin
                pace <= '0;
                sent <= '0;
                if (any_ready) begin
                    len <= sel_count;
                end
            end else if (done) begin
                pace <= '0;
            end else if (tx_busy) begin
                pace <= '0;         // Wait for transmitter to settle
            end else begin
                pace <= pace + 1'b1;
            end
            if ((state == ST_DATA) && done) begin
                sent <= sent + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* frame_pkg.sv */
`default_nettype none

package frame_pkg;

    // Frame markers
    localparam logic [7:0] HDR0     = 8'h24;
    localparam logic [7:0] HDR1     = 8'h46;
    localparam logic [7:0] HDR2     = 8'h54;
    localparam logic [7:0] HDR3     = 8'h43;
    localparam logic [7:0] END_BYTE = 8'hFE;

    // CRC-16/MODBUS, reflected
    typedef logic [15:0] crc_t;
    localparam crc_t CRC_INIT = 16'hFFFF;
    localparam crc_t CRC_POLY = 16'hA001;

    localparam logic [2:0] PACE_STROBE = 3'd4;
    localparam logic [2:0] PACE_DONE   = 3'd5;

    typedef enum logic [3:0] {
        ST_IDLE, ST_HDR0, ST_HDR1, ST_HDR2, ST_HDR3, ST_LEN,
        ST_CHAN, ST_DATA, ST_CRC_LO, ST_CRC_HI, ST_END
    } frame_state_e;

endpackage

`default_nettype wire

/* mrx_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mrx_top import chan_pkg::*; #(
    parameter int NUM_CHAN = 4,
    parameter int TICK_DIV = TICK_DIV_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  byte_t [NUM_CHAN-1:0]  rx_data,
    input  logic [NUM_CHAN-1:0]   rx_valid,
    input  trig_t [NUM_CHAN-1:0]  timer_trig,
    input  logic                  tx_busy,
    output byte_t                 tx_data,
    output logic                  tx_strobe
);

    logic                 tick;
    logic [NUM_CHAN-1:0]  ready;
    byte_t [NUM_CHAN-1:0] heads;
    cnt_t [NUM_CHAN-1:0]  counts;
    logic [NUM_CHAN-1:0]  pop_vec;
    logic [NUM_CHAN-1:0]  granted_vec;
    logic                 any_ready;
    byte_t                sel_chan;
    cnt_t                 sel_count;
    byte_t                sel_data;
    logic                 grant;
    logic                 pop;
    logic                 crc_clear;
    logic                 crc_en;
    byte_t                crc_byte;
    frame_pkg::crc_t      crc_value;

    tick_gen #(.TICK_DIV(TICK_DIV)) u_tick (.clk(clk), .rst_n(rst_n), .tick(tick));

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        rx_channel_buf u_buf (
            .clk        (clk),
            .rst_n      (rst_n),
            .tick       (tick),
            .wr_data    (rx_data[i]),
            .wr_en      (rx_valid[i]),
            .timer_trig (timer_trig[i]),
            .granted    (granted_vec[i]),
            .pop        (pop_vec[i]),
            .head       (heads[i]),
            .count      (counts[i]),
            .ready      (ready[i])
        );
    end

    channel_select #(.NUM_CHAN(NUM_CHAN)) u_sel (
        .clk(clk), .rst_n(rst_n), .ready(ready), .heads(heads), .counts(counts),
        .grant(grant), .pop(pop), .any_ready(any_ready), .sel_chan(sel_chan),
        .sel_count(sel_count), .sel_data(sel_data), .pop_vec(pop_vec),
        .granted_vec(granted_vec)
    );

    crc16_calc u_crc (
        .clk(clk), .rst_n(rst_n), .clear(crc_clear), .en(crc_en),
        .data_in(crc_byte), .crc(crc_value)
    );

    frame_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .any_ready(any_ready), .sel_chan(sel_chan),
        .sel_count(sel_count), .sel_data(sel_data), .crc_value(crc_value),
        .tx_busy(tx_busy), .grant(grant), .pop(pop), .crc_clear(crc_clear),
        .crc_en(crc_en), .crc_byte(crc_byte), .tx_data(tx_data), .tx_strobe(tx_strobe)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mrx -f sources.f -o sim_tb_mrx
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_mrx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* rx_channel_buf.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_channel_buf import chan_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tick,
    input  byte_t wr_data,
    input  logic  wr_en,
    input  trig_t timer_trig,
    input  logic  granted,
    input  logic  pop,
    output byte_t head,
    output cnt_t  count,
    output logic  ready
);

    localparam int AW = $clog2(BUF_DEPTH);

    byte_t         mem [BUF_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    trig_t         idle_cnt;
    logic          full;
    logic          push;
    logic          do_pop;

    assign full   = (count == cnt_t'(BUF_DEPTH));
    assign push   = wr_en && !full;     // Bytes into a full buffer are lost
    assign do_pop = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Show-ahead read
    assign head = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Line idle time, saturates at the timeout
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_cnt <= '0;
        end else if (wr_en || granted) begin
            idle_cnt <= '0;
        end else if (tick && (idle_cnt < timer_trig)) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign ready = (count != '0) && ((idle_cnt >= timer_trig) || full);

endmodule

`default_nettype wire

/* sources.f */
chan_pkg.sv
frame_pkg.sv
tick_gen.sv
rx_channel_buf.sv
channel_select.sv
crc16_calc.sv
frame_fsm.sv
mrx_top.sv
tb_mrx.sv

/* tb_mrx.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mrx;

    localparam int NUM_CHAN    = 4;
    localparam int TICK_DIV    = 10;
    localparam int BUF_DEPTH   = 16;
    localparam int CLK_NS      = 40;
    localparam int FRAME_WORST = 700;   // 25 bytes at up to 15 cycles, plus idle timeout
    localparam int WATCHDOG_NS = 4 * (37 * FRAME_WORST + 600) * CLK_NS;
    localparam logic [7:0] HDR [4] = '{8'h24, 8'h46, 8'h54, 8'h43};

    logic                     clk;
    logic                     rst_n;
    logic [NUM_CHAN-1:0][7:0] rx_data;
    logic [NUM_CHAN-1:0]      rx_valid;
    logic [NUM_CHAN-1:0][7:0] timer_trig;
    logic                     tx_busy = 1'b0;
    logic [7:0]               tx_data;
    logic                     tx_strobe;

    logic [31:0] stim_seed   = 32'h869400ac;
    logic [31:0] busy_seed   = 32'h869400ac;
    int          busy_r;
    int          busy_left   = 0;
    logic        force_busy  = 1'b0;
    logic        strobe_seen = 1'b0;

    // Reference model state
    logic [7:0]  model_q [NUM_CHAN][$];
    logic [7:0]  frame_q [$];
    logic [7:0]  exp_pay [$];
    logic [15:0] exp_crc;
    int          frame_chans [$];
    int          frame_lens [$];
    int          cur_chan    = 0;
    int          frames_done = 0;
    int          strobe_cnt  = 0;
    int          dropped     = 0;
    int          errors      = 0;
    int          checks      = 0;

    mrx_top #(.NUM_CHAN(NUM_CHAN), .TICK_DIV(TICK_DIV)) dut0 (
        .clk(clk), .rst_n(rst_n), .rx_data(rx_data), .rx_valid(rx_valid),
        .timer_trig(timer_trig), .tx_busy(tx_busy), .tx_data(tx_data), .tx_strobe(tx_strobe)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic rand_bits(inout logic [31:0] seed, input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            seed = lfsr_step(seed);
            val = (val << 1) | int'(seed[0]);
        end
    endtask

    // Bitwise MODBUS update taking the LSB first
    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] b);
        logic mix;
        for (int i = 0; i < 8; i++) begin
            mix = crc[0] ^ b[i];
            crc = crc >> 1;
            if (mix) begin
                crc = crc ^ 16'hA001;
            end
        end
        return crc;
    endfunction

    task automatic check_val(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, got, want);
            errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("ERROR at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic compare_frame();
        logic [7:0] want [$];
        for (int i = 0; i < 4; i++) begin
            want.push_back(HDR[i]);
        end
        want.push_back(8'(exp_pay.size()));
        want.push_back(8'(cur_chan + 1));
        foreach (exp_pay[i]) begin
            want.push_back(exp_pay[i]);
        end
        want.push_back(exp_crc[7:0]);       // Low byte first
        want.push_back(exp_crc[15:8]);
        want.push_back(8'hFE);
        check_val("frame size", frame_q.size(), want.size());
        for (int i = 0; i < want.size() && i < frame_q.size(); i++) begin
            check_val($sformatf("tx_data[byte %0d]", i), int'(frame_q[i]), int'(want[i]));
        end
        frame_chans.push_back(int'(frame_q[5]));
        frame_lens.push_back(int'(frame_q[4]));
        frames_done++;
        frame_q.delete();
        exp_pay.delete();
    endtask

    task automatic collect_tx_byte();
        int pos;
        pos = frame_q.size() - 1;
        if (pos == 5) begin
            cur_chan = int'(frame_q[5]) - 1;
            exp_crc  = 16'hFFFF;
            check_true(cur_chan >= 0 && cur_chan < NUM_CHAN, "channel byte out of range");
        end else if (pos > 5 && pos < 6 + int'(frame_q[4])) begin
            if (cur_chan >= 0 && cur_chan < NUM_CHAN && model_q[cur_chan].size() > 0) begin
                exp_pay.push_back(model_q[cur_chan].pop_front());
                exp_crc = crc_step(exp_crc, exp_pay[$]);
            end else begin
                check_true(1'b0, "payload byte sent but the channel model is empty");
            end
        end
        if (pos >= 4 && pos == 8 + int'(frame_q[4])) begin
            compare_frame();
        end
    endtask

    // Outputs and inputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            for (int c = 0; c < NUM_CHAN; c++) begin
                if (rx_valid[c] && model_q[c].size() < BUF_DEPTH) begin
                    model_q[c].push_back(rx_data[c]);
                end else if (rx_valid[c]) begin
                    dropped++;                  // Buffer full
                end
            end
            if (tx_strobe) begin
                strobe_seen = 1'b1;
                strobe_cnt++;
                check_true(!tx_busy, "tx_strobe issued while tx_busy was high");
                frame_q.push_back(tx_data);
                collect_tx_byte();
            end
        end
    end

    // Transmitter model holds busy 1 to 8 cycles after each strobe
    always @(posedge clk) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            busy_left = 0;
        end else begin
            if (strobe_seen) begin
                rand_bits(busy_seed, 3, busy_r);
                busy_left   = busy_r + 1;
                strobe_seen = 1'b0;
            end
            tx_busy <= force_busy || (busy_left > 0);
            if (busy_left > 0) begin
                busy_left--;
            end
        end
    end

    task automatic push_byte(input int ch, input logic [7:0] b);
        @(posedge clk);
        rx_valid    <= NUM_CHAN'(1) << ch;
        rx_data[ch] <= b;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            rx_valid <= '0;
        end
    endtask

    task automatic send_burst(input int ch, input int len, input int gap_bits);
        int b;
        int g;
        for (int i = 0; i < len; i++) begin
            rand_bits(stim_seed, 8, b);
            push_byte(ch, 8'(b));
            if (gap_bits > 0) begin
                rand_bits(stim_seed, gap_bits, g);
                idle_cycles(g);
            end
        end
        idle_cycles(1);
    endtask

    task automatic wait_frames(input int target, input int limit);
        int n;
        n = 0;
        while (frames_done < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        check_true(frames_done >= target, "timed out waiting for a frame");
    endtask

    task automatic report_test(input int num, input string name, input int err0);
        $display("Test %0d %s done with %0d errors", num, name, errors - err0);
    endtask

    initial begin
        int ch;
        int len;
        int r;
        int e0;
        int f0;
        int d0;
        int snap;
        rst_n      = 1'b0;
        rx_valid   = '0;
        rx_data    = '0;
        timer_trig = {NUM_CHAN{8'hFF}};
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(5);

        // Single burst with gaps below the timeout
        e0 = errors;
        f0 = frames_done;
        rand_bits(stim_seed, 2, ch);
        rand_bits(stim_seed, 4, r);
        len = 1 + r % 12;
        @(posedge clk);
        timer_trig[ch] <= 8'd4;
        send_burst(ch, len, 4);
        wait_frames(f0 + 1, FRAME_WORST);
        idle_cycles(200);
        check_val("frame count", frames_done, f0 + 1);
        if (frames_done > f0) begin
            check_val("length byte", frame_lens[f0], len);
            check_val("channel byte", frame_chans[f0], ch + 1);
        end
        report_test(1, "single burst", e0);

        // CRC over random frames
        e0 = errors;
        f0 = frames_done;
        @(posedge clk);
        timer_trig <= {NUM_CHAN{8'd3}};
        for (int f = 0; f < 30; f++) begin
            rand_bits(stim_seed, 2, ch);
            rand_bits(stim_seed, 4, r);
            len = 1 + r % 12;
            send_burst(ch, len, 3);
            wait_frames(f0 + f + 1, FRAME_WORST);
            if (frames_done > f0 + f) begin
                check_val("length byte", frame_lens[f0 + f], len);
                check_val("channel byte", frame_chans[f0 + f], ch + 1);
            end
        end
        check_val("frame count", frames_done, f0 + 30);
        report_test(2, "random frames with CRC", e0);

        // All channels at once
        e0 = errors;
        f0 = frames_done;
        rand_bits(stim_seed, 32, r);
        @(posedge clk);
        rx_valid <= '1;
        rx_data  <= (NUM_CHAN * 8)'(r);
        idle_cycles(1);
        wait_frames(f0 + NUM_CHAN, NUM_CHAN * FRAME_WORST);
        for (int c = 0; c < NUM_CHAN && f0 + c < frames_done; c++) begin
            check_val("channel byte", frame_chans[f0 + c], c + 1);
            check_val("length byte", frame_lens[f0 + c], 1);
        end
        report_test(3, "priority order", e0);

        // Full buffer frame comes well before the 2550 cycle timeout
        e0 = errors;
        f0 = frames_done;
        d0 = dropped;
        rand_bits(stim_seed, 2, ch);
        @(posedge clk);
        timer_trig[ch] <= 8'd255;
        for (int i = 0; i < 17; i++) begin
            rand_bits(stim_seed, 8, r);
            push_byte(ch, 8'(r));
        end
        idle_cycles(1);
        wait_frames(f0 + 1, FRAME_WORST);
        check_val("dropped bytes", dropped - d0, 1);
        if (frames_done > f0) begin
            check_val("length byte", frame_lens[f0], BUF_DEPTH);
            check_val("channel byte", frame_chans[f0], ch + 1);
        end
        check_val("bytes left in channel", model_q[ch].size(), 0);
        report_test(4, "full buffer", e0);

        // Long busy stretch in mid frame
        e0 = errors;
        f0 = frames_done;
        rand_bits(stim_seed, 2, ch);
        @(posedge clk);
        timer_trig[ch] <= 8'd3;
        send_burst(ch, 12, 0);
        r = 0;
        while (frame_q.size() < 8 && r < FRAME_WORST) begin
            @(posedge clk);
            r++;
        end
        check_true(frame_q.size() >= 8, "frame did not start");
        rand_bits(stim_seed, 8, r);
        @(posedge clk);
        force_busy <= 1'b1;
        repeat (2) @(posedge clk);
        snap = strobe_cnt;
        repeat (50 + r) @(posedge clk);
        check_val("strobes while busy", strobe_cnt - snap, 0);
        force_busy <= 1'b0;
        wait_frames(f0 + 1, FRAME_WORST);
        if (frames_done > f0) begin
            check_val("length byte", frame_lens[f0], 12);
            check_val("channel byte", frame_chans[f0], ch + 1);
        end
        report_test(5, "busy hold", e0);

        $display("Checks: %0d, errors: %0d, frames: %0d", checks, errors, frames_done);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tick_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tick_gen import chan_pkg::*; #(
    parameter int TICK_DIV = TICK_DIV_DEFAULT
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CW-1:0] div_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == CW'(TICK_DIV - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;    // One cycle per period
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

`default_nettype wire
